// ==== nx_agg.f ====
+incdir+src
src/nx_msg_pkg.sv
src/nx_agg_pkg.sv
src/nx_stream_arbiter.sv
src/nx_aggregator.sv
src/nx_output_row.sv
tb/tb_nx_output_row.sv

// ==== tb/tb_nx_output_row.sv ====
// Testbench for the output row: random traffic from every column and the chain input
// Scoreboards host traffic per source, checks captured outputs, fairness and drain

`default_nettype none

`include "nx_macros.svh"

module tb_nx_output_row
    import nx_msg_pkg::*,
           nx_agg_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    // ==============================
    // Limits
    // ==============================

    localparam int HANDSHAKE_LIMIT = 400;
    localparam int DRAIN_LIMIT     = 400;
    // Far end gets one host slot in 2^N, plus pipeline fill
    localparam int FAIR_LIMIT      = (1 << `NX_COLUMNS) + 2 * `NX_COLUMNS;

    logic                                 i_clk = 1'b0;
    logic                                 i_reset;
    logic                                 i_host_ready;
    logic                                 random_ready;
    logic                                 burst;
    node_message_t [`NX_COLUMNS-1:0]      mesh_data;
    logic [`NX_COLUMNS-1:0]               mesh_valid;
    logic [`NX_COLUMNS-1:0]               o_mesh_ready;
    logic                                 o_chain_ready;
    node_message_t                        o_host_data;
    logic                                 o_host_valid;
    logic [`NX_COLUMNS*`NX_OUTPUTS-1:0]   o_outputs;
    logic                                 o_idle;

    // Source k is mesh column k, source NX_COLUMNS is the chain input
    node_message_t src_data  [0:`NX_COLUMNS];
    logic          src_valid [0:`NX_COLUMNS];
    node_message_t exp_q     [0:`NX_COLUMNS][$];
    outputs_t      model_out [0:`NX_COLUMNS];
    int            gap       [0:`NX_COLUMNS];
    int            checks = 0;
    int            errors = 0;

    always #2 i_clk = !i_clk;

    for (genvar k = 0; k < `NX_COLUMNS; k++) begin : gen_src
        assign mesh_data[k]  = src_data[k];
        assign mesh_valid[k] = src_valid[k];
    end

    nx_output_row dut_i (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_mesh_data   (mesh_data),
        .i_mesh_valid  (mesh_valid),
        .o_mesh_ready  (o_mesh_ready),
        .i_chain_data  (src_data[`NX_COLUMNS]),
        .i_chain_valid (src_valid[`NX_COLUMNS]),
        .o_chain_ready (o_chain_ready),
        .o_host_data   (o_host_data),
        .o_host_valid  (o_host_valid),
        .i_host_ready  (i_host_ready),
        .o_outputs     (o_outputs),
        .o_idle        (o_idle)
    );

    // ==============================
    // Reference model and checks
    // ==============================

    // Captured only by a signal on its own column, row is ignored
    function automatic bit model_capture(input int src, input node_message_t msg,
                                         input outputs_t old, output outputs_t upd);
        upd = old;
        if (src >= `NX_COLUMNS || msg.signal.header.command != NODE_COMMAND_SIGNAL ||
            msg.signal.header.target_column != src) begin
            return 1'b0;
        end
        upd[msg.signal.address % `NX_OUTPUTS] = msg.signal.data;
        return 1'b1;
    endfunction

    // Row field tags the source, half the time a signal for the own column
    function automatic node_message_t make_message(input int src, input bit forward_only);
        node_message_t msg;
        msg.raw = $urandom;
        if (forward_only) begin
            if (msg.signal.header.command == NODE_COMMAND_SIGNAL) begin
                msg.signal.header.command = NODE_COMMAND_TRACE;
            end
        end else if ($urandom % 2) begin
            msg.signal.header.command       = NODE_COMMAND_SIGNAL;
            msg.signal.header.target_column = node_coord_t'(src);
        end
        msg.signal.header.target_row = node_coord_t'(src);
        return msg;
    endfunction

    function automatic logic source_ready(input int s);
        return (s < `NX_COLUMNS) ? o_mesh_ready[s] : o_chain_ready;
    endfunction

    task automatic check_message(input string name, input node_message_t exp,
                                 input node_message_t act);
        checks++;
        if (act.raw !== exp.raw) begin
            errors++;
            $display("ERROR %s: expected %h, actual %h", name, exp.raw, act.raw);
        end
    endtask

    task automatic check_outputs(input string name, input outputs_t exp, input outputs_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERROR %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Checks run: %0d, errors: %0d", checks, errors + 1);
        $display("Simulation FAILED");
        $finish;
    endtask

    // ==============================
    // Stimulus
    // ==============================

    task automatic run_source(input int s, input int count, input bit contend);
        node_message_t msg;
        outputs_t      upd;
        bit            captured;
        int            t;
        @(negedge i_clk);
        for (int n = 0; n < count; n++) begin
            if (!contend) begin
                repeat ($urandom % 3) @(negedge i_clk);
            end
            msg          = make_message(s, contend);
            src_data[s]  = msg;
            src_valid[s] = 1'b1;
            // Ready settles in the low phase, transfer on the next rising edge
            t = 0;
            #1;
            while (!source_ready(s)) begin
                t++;
                if (t > HANDSHAKE_LIMIT) begin
                    abort_run($sformatf("Source %0d never saw ready for its message", s));
                end
                @(negedge i_clk);
                #1;
            end
            @(posedge i_clk);
            captured = model_capture(s, msg, model_out[s], upd);
            if (captured) begin
                model_out[s] = upd;
            end else begin
                exp_q[s].push_back(msg);
            end
            @(negedge i_clk);
            src_valid[s] = 1'b0;
            if (captured) begin
                check_outputs($sformatf("signal capture col %0d", s), model_out[s],
                              o_outputs[s*`NX_OUTPUTS +: `NX_OUTPUTS]);
            end
        end
    endtask

    // One process per source
    task automatic run_phase(input int count, input bit contend);
        for (int s = 0; s <= `NX_COLUMNS; s++) begin
            fork
                automatic int src = s;
                run_source(src, count, contend);
            join_none
        end
        wait fork;
    endtask

    task automatic drain(input string phase);
        int t;
        t = 0;
        do begin
            @(negedge i_clk);
            #1;
            t++;
            if (t > DRAIN_LIMIT) begin
                abort_run($sformatf("Row did not return to idle after the %s", phase));
            end
        end while (!o_idle);
        for (int s = 0; s <= `NX_COLUMNS; s++) begin
            checks++;
            if (exp_q[s].size() != 0) begin
                errors++;
                $display("ERROR %s source %0d pending: expected 0, actual %0d",
                         phase, s, exp_q[s].size());
            end
        end
    endtask

    // Host ready is random about half the time in the first phase
    always @(negedge i_clk) begin
        i_host_ready = random_ready ? 1'($urandom % 2) : 1'b1;
    end

    // ==============================
    // Host scoreboard
    // ==============================

    always @(negedge i_clk) begin : host_monitor
        int src;
        #1;
        if (!i_reset && o_host_valid && i_host_ready) begin
            src = int'(o_host_data.signal.header.target_row);
            if (src > `NX_COLUMNS || exp_q[src].size() == 0) begin
                errors++;
                $display("Unexpected host message %h with nothing pending for its source",
                         o_host_data.raw);
            end else begin
                check_message($sformatf("host from source %0d", src),
                              exp_q[src].pop_front(), o_host_data);
                if (burst) begin
                    for (int s = 0; s <= `NX_COLUMNS; s++) begin
                        if (gap[s] >= 0) gap[s]++;
                    end
                    checks++;
                    if (gap[src] > FAIR_LIMIT) begin
                        errors++;
                        $display("ERROR fairness source %0d: expected at most %0d, actual %0d",
                                 src, FAIR_LIMIT, gap[src]);
                    end
                    gap[src] = 0;
                end
            end
        end
    end

    initial begin : main
        void'($urandom(18));
        i_reset      = 1'b1;
        i_host_ready = 1'b1;
        random_ready = 1'b0;
        burst        = 1'b0;
        for (int s = 0; s <= `NX_COLUMNS; s++) begin
            src_data[s]  = '0;
            src_valid[s] = 1'b0;
            model_out[s] = '0;
            gap[s]       = -1;
        end
        repeat (10) @(posedge i_clk);
        @(negedge i_clk);
        i_reset = 1'b0;
        @(negedge i_clk);
        for (int c = 0; c < `NX_COLUMNS; c++) begin
            check_outputs($sformatf("reset col %0d", c), '0,
                          o_outputs[c*`NX_OUTPUTS +: `NX_OUTPUTS]);
        end
        checks++;
        if (o_host_valid !== 1'b0 || o_idle !== 1'b1) begin
            errors++;
            $display("ERROR reset: expected valid 0 idle 1, actual valid %b idle %b",
                     o_host_valid, o_idle);
        end
        // Capture, forwarding and back-pressure
        random_ready = 1'b1;
        run_phase(40, 1'b0);
        random_ready = 1'b0;
        drain("back-pressure phase");
        // Every source valid, host always ready
        burst = 1'b1;
        run_phase(24, 1'b1);
        drain("contention phase");
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule : tb_nx_output_row

`default_nettype wire

// ==== src/nx_output_row.sv ====
// Output-collection row: a chain of aggregators, one per mesh column
// Column 0 feeds the host link, the far end takes another row segment

`default_nettype none

`include "nx_macros.svh"

module nx_output_row
    import nx_msg_pkg::*,
           nx_agg_pkg::*;
(
    input  wire logic                               i_clk,
    input  wire logic                               i_reset,
    // Mesh columns
    input  wire node_message_t [`NX_COLUMNS-1:0]    i_mesh_data,
    input  wire logic [`NX_COLUMNS-1:0]             i_mesh_valid,
    output logic [`NX_COLUMNS-1:0]                  o_mesh_ready,
    // Far end of the chain
    input  wire node_message_t                      i_chain_data,
    input  wire logic                               i_chain_valid,
    output logic                                    o_chain_ready,
    // Host link
    output node_message_t                           o_host_data,
    output logic                                    o_host_valid,
    input  wire logic                               i_host_ready,
    // Status
    output logic [`NX_COLUMNS*`NX_OUTPUTS-1:0]      o_outputs,
    output logic                                    o_idle
);

    // ==============================
    // Chain links
    // ==============================

    // Link k is aggregator k's outbound, link NX_COLUMNS is the chain input
    node_message_t [`NX_COLUMNS:0] link_data;
    logic [`NX_COLUMNS:0]          link_valid;
    logic [`NX_COLUMNS:0]          link_ready;
    logic [`NX_COLUMNS-1:0]        col_idle;

    assign link_data[`NX_COLUMNS]  = i_chain_data;
    assign link_valid[`NX_COLUMNS] = i_chain_valid;
    assign o_chain_ready           = link_ready[`NX_COLUMNS];

    assign o_host_data   = link_data[0];
    assign o_host_valid  = link_valid[0];
    assign link_ready[0] = i_host_ready;

    // ==============================
    // Aggregators
    // ==============================

    for (genvar k = 0; k < `NX_COLUMNS; k++) begin : gen_col
        nx_aggregator #(
            .COLUMN (column_t'(k))
        ) u_agg (
            .i_clk               (i_clk),
            .i_reset             (i_reset),
            .o_idle              (col_idle[k]),
            .o_outputs           (o_outputs[k*`NX_OUTPUTS +: `NX_OUTPUTS]),
            .i_inbound_data      (i_mesh_data[k]),
            .i_inbound_valid     (i_mesh_valid[k]),
            .o_inbound_ready     (o_mesh_ready[k]),
            .i_passthrough_data  (link_data[k+1]),
            .i_passthrough_valid (link_valid[k+1]),
            .o_passthrough_ready (link_ready[k+1]),
            .o_outbound_data     (link_data[k]),
            .o_outbound_valid    (link_valid[k]),
            .i_outbound_ready    (link_ready[k])
        );
    end

    // Row is idle only when every column is
    assign o_idle = &col_idle;

endmodule : nx_output_row

`default_nettype wire

// ==== src/nx_aggregator.sv ====
// One column's aggregator: captures signals for its column into output state
// Everything else is merged with the chain passthrough and sent towards the host

`default_nettype none

module nx_aggregator
    import nx_msg_pkg::*,
           nx_agg_pkg::*;
#(
    parameter column_t COLUMN = '0
) (
    input  wire logic          i_clk,
    input  wire logic          i_reset,
    // Status
    output logic               o_idle,
    output outputs_t           o_outputs,
    // From this column of the mesh
    input  wire node_message_t i_inbound_data,
    input  wire logic          i_inbound_valid,
    output logic               o_inbound_ready,
    // From the next aggregator along the chain
    input  wire node_message_t i_passthrough_data,
    input  wire logic          i_passthrough_valid,
    output logic               o_passthrough_ready,
    // Towards the host
    output node_message_t      o_outbound_data,
    output logic               o_outbound_valid,
    input  wire logic          i_outbound_ready
);

    // ==============================
    // Signal detection
    // ==============================

    logic                is_signal;
    out_addr_t           sig_addr;
    logic                sig_data;
    outputs_t            outputs_q;

    // Arbiter hookup, slot 0 mesh and slot 1 passthrough
    node_message_t [1:0] arb_data;
    logic [1:0]          arb_valid;
    logic [1:0]          arb_ready;

    // Column match only, row is not checked
    assign is_signal = i_inbound_valid &&
        (i_inbound_data.signal.header.command == NODE_COMMAND_SIGNAL) &&
        (i_inbound_data.signal.header.target_column == COLUMN);

    // Low address bits pick the output
    assign sig_addr = i_inbound_data.signal.address[OUT_ADDR_WIDTH-1:0];
    assign sig_data = i_inbound_data.signal.data;

    // ==============================
    // Output state
    // ==============================

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            outputs_q <= '0;
        end else if (is_signal) begin
            outputs_q[sig_addr] <= sig_data;
        end
    end

    assign o_outputs = outputs_q;

    // ==============================
    // Merge with passthrough
    // ==============================

    assign arb_data[0]  = i_inbound_data;
    assign arb_valid[0] = i_inbound_valid && !is_signal;
    assign arb_data[1]  = i_passthrough_data;
    assign arb_valid[1] = i_passthrough_valid;

    // Captured signals are always taken at once
    assign o_inbound_ready     = is_signal || arb_ready[0];
    assign o_passthrough_ready = arb_ready[1];

    nx_stream_arbiter u_arbiter (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_in_data   (arb_data),
        .i_in_valid  (arb_valid),
        .o_in_ready  (arb_ready),
        .o_out_data  (o_outbound_data),
        .o_out_valid (o_outbound_valid),
        .i_out_ready (i_outbound_ready)
    );

    // Nothing offered and nothing held in the slot
    assign o_idle = !i_inbound_valid && !i_passthrough_valid && !o_outbound_valid;

    // Mesh side holds an offered message until it is taken
    assert property (@(posedge i_clk) disable iff (i_reset)
        (i_inbound_valid && !o_inbound_ready) |=>
            (i_inbound_valid && $stable(i_inbound_data)))
        else $error("Mesh message dropped or changed before it was taken");

endmodule : nx_aggregator

`default_nettype wire

// ==== src/nx_stream_arbiter.sv ====
// Two-input round-robin merge of valid/ready message streams
// Winner is loaded into one registered outbound slot, refilled as it drains

`default_nettype none

module nx_stream_arbiter
    import nx_msg_pkg::*;
(
    input  wire logic              i_clk,
    input  wire logic              i_reset,
    // Inbound streams
    input  wire node_message_t [1:0] i_in_data,
    input  wire logic [1:0]        i_in_valid,
    output logic [1:0]             o_in_ready,
    // Outbound stream
    output node_message_t          o_out_data,
    output logic                   o_out_valid,
    input  wire logic              i_out_ready
);

    // ==============================
    // State
    // ==============================

    // Registered outbound slot
    node_message_t slot_data_q;
    logic          slot_valid_q;

    // Index of the input that won the last contended or single grant
    logic          last_q;

    // Combinational grant
    logic          can_load;
    logic          pick;
    logic [1:0]    grant;

    // ==============================
    // Grant selection
    // ==============================

    // Slot takes new data when empty or draining this cycle
    assign can_load = !slot_valid_q || i_out_ready;

    // Both valid, the loser of last time wins
    // Single valid, that input wins
    assign pick = (&i_in_valid) ? !last_q : i_in_valid[1];

    assign grant[0] = can_load && i_in_valid[0] && !pick;
    assign grant[1] = can_load && i_in_valid[1] && pick;

    // Ready only for the winner, low under back-pressure
    assign o_in_ready = grant;

    // ==============================
    // Slot and pointer
    // ==============================

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            slot_valid_q <= 1'b0;
            // Points at input 1 so input 0 goes first
            last_q       <= 1'b1;
        end else begin
            if (|grant) begin
                slot_valid_q <= 1'b1;
                last_q       <= pick;
            end else if (i_out_ready) begin
                slot_valid_q <= 1'b0;
            end
        end
    end

    // Payload only moves on a grant
    always_ff @(posedge i_clk) begin
        if (|grant) begin
            slot_data_q <= i_in_data[pick];
        end
    end

    assign o_out_data  = slot_data_q;
    assign o_out_valid = slot_valid_q;

    // ==============================
    // Checks
    // ==============================

    // Stalled slot keeps its message until taken
    assert property (@(posedge i_clk) disable iff (i_reset)
        (o_out_valid && !i_out_ready) |=> (o_out_valid && $stable(o_out_data)))
        else $error("Outbound message changed while stalled");

    // Back-to-back contended grants go to opposite inputs
    assert property (@(posedge i_clk) disable iff (i_reset)
        ((&i_in_valid) && (|o_in_ready) &&
         $past((&i_in_valid) && (|o_in_ready) && !i_reset))
            |-> (o_in_ready != $past(o_in_ready)))
        else $error("Contended grant did not alternate");

endmodule : nx_stream_arbiter

`default_nettype wire

// ==== src/nx_agg_pkg.sv ====
// Aggregator-side types for output state and column identity
// Import in the aggregator and in the row top level

`default_nettype none

`include "nx_macros.svh"

package nx_agg_pkg;

    // Bits of address needed to pick one output
    localparam int OUT_ADDR_WIDTH = $clog2(`NX_OUTPUTS);

    // One aggregator's output state register
    typedef logic [`NX_OUTPUTS-1:0] outputs_t;

    // Output index, taken from the low signal address bits
    typedef logic [OUT_ADDR_WIDTH-1:0] out_addr_t;

    // Own column of an aggregator
    typedef logic [`NX_COORD_WIDTH-1:0] column_t;

endpackage : nx_agg_pkg

`default_nettype wire

// ==== src/nx_msg_pkg.sv ====
// Message format carried over the mesh and along the aggregator chain
// Import wherever a stream or a message field is handled

`default_nettype none

`include "nx_macros.svh"

package nx_msg_pkg;

    // ==============================
    // Field widths
    // ==============================

    // Header is two coordinates plus the 2-bit command
    localparam int NODE_HEADER_WIDTH = (2 * `NX_COORD_WIDTH) + 2;

    // Whatever the signal view leaves unused at the bottom of the word
    localparam int NODE_SIGNAL_PAD = `NX_MSG_WIDTH - NODE_HEADER_WIDTH - `NX_ADDR_WIDTH - 1;

    // ==============================
    // Types
    // ==============================

    // Only SIGNAL is acted on by the aggregators
    typedef enum logic [1:0] {
        NODE_COMMAND_LOAD    = 2'd0,
        NODE_COMMAND_SIGNAL  = 2'd1,
        NODE_COMMAND_TRACE   = 2'd2,
        NODE_COMMAND_CONTROL = 2'd3
    } node_command_t;

    typedef logic [`NX_COORD_WIDTH-1:0] node_coord_t;
    typedef logic [`NX_ADDR_WIDTH-1:0]  node_addr_t;
    typedef logic [`NX_MSG_WIDTH-1:0]   node_raw_t;

    typedef struct packed {
        node_coord_t   target_row;
        node_coord_t   target_column;
        node_command_t command;
    } node_header_t;

    // Signal view, MSB first
    typedef struct packed {
        node_header_t                 header;
        node_addr_t                   address;
        logic                         data;
        logic [NODE_SIGNAL_PAD-1:0]   padding;
    } node_signal_t;

    // Same 32 bits seen raw or as a signal
    typedef union packed {
        node_raw_t    raw;
        node_signal_t signal;
    } node_message_t;

endpackage : nx_msg_pkg

`default_nettype wire

// ==== src/nx_macros.svh ====
// Build-time sizing for the output-collection row
// Included by the packages and by any module that sizes ports from these values

`ifndef NX_MACROS_SVH
`define NX_MACROS_SVH

// ==============================
// Row geometry
// ==============================

// Aggregators in the row, one per mesh column
`define NX_COLUMNS 4

// Output state bits held by each aggregator
`define NX_OUTPUTS 8

// ==============================
// Message field widths
// ==============================

`define NX_ADDR_WIDTH  5
`define NX_COORD_WIDTH 4
`define NX_MSG_WIDTH   32

`endif
